//--- src/cmd_decoder.sv
//####################
// command decoder
// turns received bytes into pixel writes and display settings
//####################
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_cfg.svh"

module cmd_decoder (
    input wire clk_root,
    input wire arst_n,
    input wire [7:0] byte_data,
    input wire byte_valid,
    output led_panel_pkg::pixel_write_t wr,
    output led_panel_pkg::display_cfg_t cfg
);

    localparam int COL_W = $bits(led_panel_pkg::col_t);
    localparam int ROW_W = $bits(led_panel_pkg::row_t);

    logic [7:0] op;  // opcode of the command being collected
    logic [2:0] cnt; // 0 while waiting for an opcode
    logic wr_valid;
    led_panel_pkg::col_t col_q;
    led_panel_pkg::row_t row_q;
    led_panel_pkg::pixel_t data_q;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            op <= '0;
            cnt <= '0;
            wr_valid <= 1'b0;
            cfg <= '1; // everything visible out of reset
        end else begin
            wr_valid <= 1'b0;
            if (byte_valid) begin
                if (cnt == 3'd0) begin
                    if (byte_data inside {`LP_OP_PIXEL, `LP_OP_RGB_EN, `LP_OP_PLANE_EN}) begin
                        op <= byte_data;
                        cnt <= 3'd1;
                    end
                end else begin
                    unique case (op)
                        `LP_OP_PIXEL: begin
                            if (cnt == 3'd4) begin
                                cnt <= '0;
                                wr_valid <= 1'b1; // blue nibble closes the write
                            end else begin
                                cnt <= cnt + 1'b1;
                            end
                        end
                        `LP_OP_RGB_EN: begin
                            cfg.rgb_enable <= byte_data[2:0];
                            cnt <= '0;
                        end
                        `LP_OP_PLANE_EN: begin
                            cfg.plane_enable <= byte_data[`LP_PLANES-1:0];
                            cnt <= '0;
                        end
                        default: cnt <= '0;
                    endcase
                end
            end
        end
    end

    // operand capture, x and y lose their high bits
    always_ff @(posedge clk_root) begin
        if (byte_valid && op == `LP_OP_PIXEL) begin
            case (cnt)
                3'd1: col_q <= byte_data[COL_W-1:0];
                3'd2: row_q <= byte_data[ROW_W-1:0];
                3'd3: begin
                    data_q.r <= byte_data[7:4];
                    data_q.g <= byte_data[3:0];
                end
                3'd4: data_q.b <= byte_data[3:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        wr.valid = wr_valid;
        wr.col = col_q;
        wr.row = row_q;
        wr.data = data_q;
    end

    assert property (@(posedge clk_root) disable iff (!arst_n)
        wr.valid |=> !wr.valid);

endmodule

`default_nettype wire

//--- src/frame_memory.sv
//####################
// frame memory
// top and bottom half arrays, one write port, paired read
//####################
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_cfg.svh"

module frame_memory (
    input wire clk_root,
    input wire led_panel_pkg::pixel_write_t wr,
    input wire led_panel_pkg::col_t rd_col,
    input wire led_panel_pkg::half_row_t rd_row,
    output led_panel_pkg::pixel_t rd_top,
    output led_panel_pkg::pixel_t rd_bottom
);

    localparam int HALF = `LP_HEIGHT / 2;
    localparam int ROW_MSB = $bits(led_panel_pkg::row_t) - 1;

    led_panel_pkg::pixel_t mem_top [HALF][`LP_WIDTH];
    led_panel_pkg::pixel_t mem_bottom [HALF][`LP_WIDTH];

    led_panel_pkg::half_row_t wr_half_row;
    logic wr_bottom;

    assign wr_half_row = wr.row[ROW_MSB-1:0];
    assign wr_bottom = wr.row[ROW_MSB]; // rows 4..7 live in the bottom array

    always_ff @(posedge clk_root) begin
        if (wr.valid && !wr_bottom) begin
            mem_top[wr_half_row][wr.col] <= wr.data;
        end
        rd_top <= mem_top[rd_row][rd_col];
    end

    always_ff @(posedge clk_root) begin
        if (wr.valid && wr_bottom) begin
            mem_bottom[wr_half_row][wr.col] <= wr.data;
        end
        rd_bottom <= mem_bottom[rd_row][rd_col];
    end

endmodule

`default_nettype wire

//--- src/led_panel_cfg.svh
//####################
// led panel config
// panel geometry, uart timing, scan timing and command opcodes
//####################
`ifndef LED_PANEL_CFG_SVH
`define LED_PANEL_CFG_SVH

// panel geometry, split into a top and a bottom half
`define LP_WIDTH 16
`define LP_HEIGHT 8

// bits per colour channel, one scan plane per bit
`define LP_PLANES 4

// serial line timing in clk_root cycles
`define LP_TICKS_PER_BIT 8

// plane 0 on time, doubled for every higher plane
`define LP_BASE_ON 4

// command opcodes, first byte of every command
`define LP_OP_PIXEL 8'h50
`define LP_OP_RGB_EN 8'h45
`define LP_OP_PLANE_EN 8'h42

`endif

//--- src/led_panel_pkg.sv
//####################
// led panel types
// shared vectors, link structs and the scan state enum
//####################
`default_nettype none

`include "led_panel_cfg.svh"

package led_panel_pkg;

    typedef logic [$clog2(`LP_WIDTH)-1:0] col_t;
    typedef logic [$clog2(`LP_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`LP_HEIGHT/2)-1:0] half_row_t;
    typedef logic [$clog2(`LP_PLANES)-1:0] plane_t;
    typedef logic [`LP_PLANES-1:0] chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } pixel_t;

    typedef logic [2:0] rgb_bits_t; // [2] red, [1] green, [0] blue

    typedef struct packed {
        logic valid;
        col_t col;
        row_t row;
        pixel_t data;
    } pixel_write_t;

    typedef struct packed {
        rgb_bits_t rgb_enable;
        logic [`LP_PLANES-1:0] plane_enable;
    } display_cfg_t;

    typedef struct packed {
        logic shift;
        logic latch;
        logic oe;
        col_t col;
        half_row_t row;
        plane_t plane;
    } scan_ctl_t;

    typedef struct packed {
        rgb_bits_t rgb_top;
        rgb_bits_t rgb_bottom;
        half_row_t row;
        logic clk_pixel;
        logic row_latch;
        logic oe_n; // panel blanks when high
    } hub75_t;

    typedef enum logic [1:0] {
        SHIFT,
        BLANK,
        LATCH,
        DISPLAY
    } scan_state_t;

endpackage

`default_nettype wire

//--- src/led_panel_top.sv
//####################
// led panel top
// uart in, hub75 out
//####################
`timescale 1ns/1ps
`default_nettype none

module led_panel_top (
    input wire clk_root,
    input wire arst_n,
    input wire rx,
    output led_panel_pkg::hub75_t panel
);

    logic [7:0] byte_data;
    logic byte_valid;
    led_panel_pkg::pixel_write_t wr;
    led_panel_pkg::display_cfg_t cfg;
    led_panel_pkg::scan_ctl_t scan;
    led_panel_pkg::col_t rd_col;
    led_panel_pkg::half_row_t rd_row;
    led_panel_pkg::pixel_t rd_top;
    led_panel_pkg::pixel_t rd_bottom;

    uart_rx uart_rx_i (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .rx(rx),
        .byte_data(byte_data),
        .byte_valid(byte_valid)
    );

    cmd_decoder cmd_decoder_i (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .byte_data(byte_data),
        .byte_valid(byte_valid),
        .wr(wr),
        .cfg(cfg)
    );

    frame_memory frame_memory_i (
        .clk_root(clk_root),
        .wr(wr),
        .rd_col(rd_col),
        .rd_row(rd_row),
        .rd_top(rd_top),
        .rd_bottom(rd_bottom)
    );

    matrix_scan matrix_scan_i (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .scan(scan)
    );

    plane_fetch plane_fetch_i (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .scan(scan),
        .cfg(cfg),
        .rd_col(rd_col),
        .rd_row(rd_row),
        .rd_top(rd_top),
        .rd_bottom(rd_bottom),
        .panel(panel)
    );

endmodule

`default_nettype wire

//--- src/matrix_scan.sv
//####################
// matrix scan sequencer
// binary coded modulation over rows and bit planes
//####################
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_cfg.svh"

module matrix_scan (
    input wire clk_root,
    input wire arst_n,
    output led_panel_pkg::scan_ctl_t scan
);

    localparam int SC_W = $clog2(2 * `LP_WIDTH);
    localparam int ON_MAX = `LP_BASE_ON << (`LP_PLANES - 1);
    localparam int ON_W = $clog2(ON_MAX);
    localparam led_panel_pkg::plane_t PLANE_LAST = led_panel_pkg::plane_t'(`LP_PLANES - 1);
    localparam led_panel_pkg::half_row_t ROW_LAST = led_panel_pkg::half_row_t'(`LP_HEIGHT / 2 - 1);

    led_panel_pkg::scan_state_t state;
    logic [SC_W-1:0] shift_cnt; // two cycles per column
    logic [ON_W-1:0] on_cnt;    // counts down the display time
    led_panel_pkg::half_row_t row;
    led_panel_pkg::plane_t plane;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state <= led_panel_pkg::SHIFT;
            shift_cnt <= '0;
            on_cnt <= '0;
            row <= '0;
            plane <= '0;
        end else begin
            unique case (state)
                led_panel_pkg::SHIFT: begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_cnt == SC_W'(2 * `LP_WIDTH - 1)) begin
                        state <= led_panel_pkg::BLANK;
                    end
                end
                led_panel_pkg::BLANK: begin
                    state <= led_panel_pkg::LATCH;
                end
                led_panel_pkg::LATCH: begin
                    on_cnt <= ON_W'((`LP_BASE_ON << plane) - 1); // weight of this plane
                    state <= led_panel_pkg::DISPLAY;
                end
                led_panel_pkg::DISPLAY: begin
                    if (on_cnt == '0) begin
                        state <= led_panel_pkg::SHIFT;
                        shift_cnt <= '0;
                        if (plane == PLANE_LAST) begin
                            plane <= '0;
                            row <= (row == ROW_LAST) ? '0 : row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        on_cnt <= on_cnt - 1'b1;
                    end
                end
                default: state <= led_panel_pkg::SHIFT;
            endcase
        end
    end

    // second cycle of each column pair carries the pixel clock
    always_comb begin
        scan.shift = (state == led_panel_pkg::SHIFT) && shift_cnt[0];
        scan.latch = (state == led_panel_pkg::LATCH);
        scan.oe = (state == led_panel_pkg::DISPLAY);
        scan.col = shift_cnt[SC_W-1:1];
        scan.row = row;
        scan.plane = plane;
    end

    assert property (@(posedge clk_root) disable iff (!arst_n)
        !(scan.latch && scan.oe));

endmodule

`default_nettype wire

//--- src/plane_fetch.sv
//####################
// plane fetch
// picks the plane bit of each pixel and drives the hub75 pins
//####################
`timescale 1ns/1ps
`default_nettype none

module plane_fetch (
    input wire clk_root,
    input wire arst_n,
    input wire led_panel_pkg::scan_ctl_t scan,
    input wire led_panel_pkg::display_cfg_t cfg,
    output led_panel_pkg::col_t rd_col,
    output led_panel_pkg::half_row_t rd_row,
    input wire led_panel_pkg::pixel_t rd_top,
    input wire led_panel_pkg::pixel_t rd_bottom,
    output led_panel_pkg::hub75_t panel
);

    // stage 1, lines up with the memory read data
    logic s1_shift;
    logic s1_latch;
    logic s1_oe;
    led_panel_pkg::half_row_t s1_row;
    led_panel_pkg::plane_t s1_plane;
    logic gate;
    led_panel_pkg::rgb_bits_t rgb_top_d;
    led_panel_pkg::rgb_bits_t rgb_bottom_d;

    function automatic led_panel_pkg::rgb_bits_t plane_bits(
        input led_panel_pkg::pixel_t px,
        input led_panel_pkg::plane_t p,
        input led_panel_pkg::rgb_bits_t en
    );
        plane_bits = {px.r[p] & en[2], px.g[p] & en[1], px.b[p] & en[0]};
    endfunction

    assign rd_col = scan.col;
    assign rd_row = scan.row;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            s1_shift <= 1'b0;
            s1_latch <= 1'b0;
            s1_oe <= 1'b0;
            s1_row <= '0;
            s1_plane <= '0;
        end else begin
            s1_shift <= scan.shift;
            s1_latch <= scan.latch;
            s1_oe <= scan.oe;
            s1_row <= scan.row;
            s1_plane <= scan.plane;
        end
    end

    assign gate = s1_shift & cfg.plane_enable[s1_plane]; // dark outside shift cycles
    assign rgb_top_d = plane_bits(rd_top, s1_plane, cfg.rgb_enable) & {3{gate}};
    assign rgb_bottom_d = plane_bits(rd_bottom, s1_plane, cfg.rgb_enable) & {3{gate}};

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            panel.rgb_top <= '0;
            panel.rgb_bottom <= '0;
            panel.row <= '0;
            panel.clk_pixel <= 1'b0;
            panel.row_latch <= 1'b0;
            panel.oe_n <= 1'b1;
        end else begin
            panel.rgb_top <= rgb_top_d;
            panel.rgb_bottom <= rgb_bottom_d;
            if (s1_latch) begin
                panel.row <= s1_row; // row address moves with the latch
            end
            panel.clk_pixel <= s1_shift;
            panel.row_latch <= s1_latch;
            panel.oe_n <= ~s1_oe;
        end
    end

endmodule

`default_nettype wire

//--- src/uart_rx.sv
//####################
// uart receiver
// 8N1 bytes, lsb first, sampled mid bit
//####################
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_cfg.svh"

module uart_rx (
    input wire clk_root,
    input wire arst_n,
    input wire rx,
    output logic [7:0] byte_data,
    output logic byte_valid
);

    localparam int TICKS = `LP_TICKS_PER_BIT;
    localparam int TW = $clog2(TICKS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;
    logic [1:0] rx_sync; // two flop synchroniser
    logic rx_last;       // previous synced value, for the start edge
    logic [TW-1:0] tick;
    logic [2:0] bit_idx;
    logic [7:0] shreg;
    logic bit_end;

    assign bit_end = (tick == TW'(TICKS - 1));

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11; // line idles high
            rx_last <= 1'b1;
            state <= RX_IDLE;
            tick <= '0;
            bit_idx <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_last <= rx_sync[1];
            byte_valid <= 1'b0;
            unique case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (rx_last && !rx_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick == TW'(TICKS / 2 - 1)) begin
                        tick <= '0;
                        bit_idx <= '0;
                        state <= rx_sync[1] ? RX_IDLE : RX_DATA; // glitch, not a start bit
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        tick <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state <= RX_IDLE;
                        byte_valid <= rx_sync[1]; // framing error drops the byte
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && bit_end) begin
            shreg <= {rx_sync[1], shreg[7:1]}; // lsb arrives first
        end
        if (state == RX_STOP && bit_end && rx_sync[1]) begin
            byte_data <= shreg;
        end
    end

    // a byte takes ten bit periods, so strobes never touch
    assert property (@(posedge clk_root) disable iff (!arst_n)
        byte_valid |=> !byte_valid);

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/led_panel_pkg.sv
src/uart_rx.sv
src/cmd_decoder.sv
src/frame_memory.sv
src/matrix_scan.sv
src/plane_fetch.sv
src/led_panel_top.sv
test/tb_led_panel.sv

//--- test/tb_led_panel.sv
//####################
// led panel testbench
// uart commands in, hub75 stream checked against a pixel model
//####################
`timescale 1ns/1ps
`default_nettype none

`include "led_panel_cfg.svh"

module tb_led_panel;

    localparam int TICKS = `LP_TICKS_PER_BIT;
    localparam int CLK_NS = 40;
    localparam int HALF = `LP_HEIGHT / 2;
    localparam int PLANE_FIXED = 2 * `LP_WIDTH + 2; // shift, blank and latch
    localparam int ROW_CYC = `LP_PLANES * PLANE_FIXED + `LP_BASE_ON * ((1 << `LP_PLANES) - 1);
    localparam int FRAME_CYC = HALF * ROW_CYC;
    localparam int BYTE_CYC = 10 * TICKS + 3; // one 8N1 frame plus the gaps
    localparam int N_OVERWRITE = 8;
    localparam int N_BYTES = `LP_WIDTH * `LP_HEIGHT * 5 + 4 * 2 + N_OVERWRITE * 6;
    localparam int N_FRAMES = 9; // frames the stimulus waits on
    localparam longint WATCHDOG_NS =
        longint'(N_BYTES * BYTE_CYC + (N_FRAMES + 4) * FRAME_CYC + 1000) * CLK_NS;

    logic clk_root = 1'b0;
    logic arst_n;
    logic rx;
    led_panel_pkg::hub75_t panel;

    // reference model, pixels as {r, g, b}
    logic [11:0] model [`LP_WIDTH][`LP_HEIGHT];
    logic [2:0] m_rgb_en;
    logic [`LP_PLANES-1:0] m_plane_en;
    logic dirty;  // a command finished during the current plane
    logic loaded; // every pixel has a known value

    // monitor state
    int mon_row;
    int mon_plane;
    int last_plane;
    int col_cnt;
    int oe_cnt;
    int frame_cnt;
    int rst_cycles;
    logic seen_latch;
    logic [2:0] obs_top [`LP_WIDTH];
    logic [2:0] obs_bot [`LP_WIDTH];

    int pix_err;
    int tim_err;
    int pix_checks;

    led_panel_top led_panel_top_i (
        .clk_root(clk_root),
        .arst_n(arst_n),
        .rx(rx),
        .panel(panel)
    );

    always #(CLK_NS / 2) clk_root = ~clk_root;

    function automatic logic [2:0] expected_bits(
        input logic [11:0] px,
        input int p,
        input logic [2:0] rgb_en,
        input logic [`LP_PLANES-1:0] plane_en
    );
        logic [2:0] bits;
        bits = {px[8 + p], px[4 + p], px[p]} & rgb_en;
        if (!plane_en[p]) begin
            bits = 3'b000; // plane switched off
        end
        return bits;
    endfunction

    // runs on every row_latch, closes the plane that was just shifted
    task automatic check_plane();
        logic [2:0] exp_top;
        logic [2:0] exp_bot;
        if (seen_latch && oe_cnt != (`LP_BASE_ON << last_plane)) begin
            tim_err++;
            $display("Fail %0t: plane %0d shown for %0d cycles, expected %0d",
                $time, last_plane, oe_cnt, `LP_BASE_ON << last_plane);
        end
        if (col_cnt != `LP_WIDTH) begin
            tim_err++;
            $display("Fail %0t: %0d pixel clocks before latch, expected %0d",
                $time, col_cnt, `LP_WIDTH);
        end
        if (panel.row != mon_row) begin
            tim_err++;
            $display("Fail %0t: row address %0d, expected %0d", $time, panel.row, mon_row);
        end
        if (loaded && !dirty) begin
            for (int c = 0; c < `LP_WIDTH; c++) begin
                exp_top = expected_bits(model[c][mon_row], mon_plane, m_rgb_en, m_plane_en);
                exp_bot = expected_bits(model[c][mon_row + HALF], mon_plane, m_rgb_en,
                    m_plane_en);
                if (obs_top[c] !== exp_top) begin
                    pix_err++;
                    $display("Fail %0t: top col %0d row %0d plane %0d got %b expected %b",
                        $time, c, mon_row, mon_plane, obs_top[c], exp_top);
                end
                if (obs_bot[c] !== exp_bot) begin
                    pix_err++;
                    $display("Fail %0t: bottom col %0d row %0d plane %0d got %b expected %b",
                        $time, c, mon_row + HALF, mon_plane, obs_bot[c], exp_bot);
                end
                pix_checks++;
            end
        end
        dirty = 1'b0;
        seen_latch = 1'b1;
        last_plane = mon_plane;
        col_cnt = 0;
        oe_cnt = 0;
        if (mon_plane == `LP_PLANES - 1) begin
            mon_plane = 0;
            if (mon_row == HALF - 1) begin
                mon_row = 0;
                frame_cnt++;
            end else begin
                mon_row++;
            end
        end else begin
            mon_plane++;
        end
    endtask

    // panel pins sampled before the edge updates them
    always @(posedge clk_root) begin
        if (!arst_n) begin
            if (rst_cycles > 0 && (panel.oe_n !== 1'b1 || panel.row_latch !== 1'b0 ||
                    panel.clk_pixel !== 1'b0)) begin
                tim_err++;
                $display("Fail %0t: panel controls active during reset", $time);
            end
            rst_cycles++;
            mon_row = 0;
            mon_plane = 0;
            col_cnt = 0;
            oe_cnt = 0;
            seen_latch = 1'b0;
        end else begin
            if (!panel.clk_pixel && (panel.rgb_top != 3'b000 || panel.rgb_bottom != 3'b000)) begin
                pix_err++;
                $display("Fail %0t: rgb bits set outside a pixel clock", $time);
            end
            if (panel.clk_pixel) begin
                if (col_cnt < `LP_WIDTH) begin
                    obs_top[col_cnt] = panel.rgb_top;
                    obs_bot[col_cnt] = panel.rgb_bottom;
                end
                col_cnt++;
            end
            if (!panel.oe_n) begin
                if (!seen_latch) begin
                    tim_err++;
                    $display("Fail %0t: oe_n low before the first latch", $time);
                end
                oe_cnt++;
            end
            if (panel.row_latch) begin
                check_plane();
            end
        end
    end

    task automatic uart_send(input logic [7:0] b);
        @(negedge clk_root);
        rx = 1'b0; // start bit
        repeat (TICKS) @(negedge clk_root);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (TICKS) @(negedge clk_root);
        end
        rx = 1'b1;
        repeat (TICKS) @(negedge clk_root);
    endtask

    task automatic write_pixel(input logic [3:0] x, input logic [2:0] y, input logic [11:0] px);
        logic [31:0] noise;
        noise = $urandom;
        uart_send(`LP_OP_PIXEL);
        uart_send({noise[7:4], x}); // junk above the panel width
        uart_send({noise[12:8], y});
        uart_send(px[11:4]);
        uart_send({noise[19:16], px[3:0]});
        repeat (2) @(negedge clk_root); // write is in memory by now
        model[x][y] = px;
        dirty = 1'b1;
    endtask

    // settings register is already live when the stop bit ends
    task automatic set_rgb_enable(input logic [2:0] en);
        logic [31:0] noise;
        noise = $urandom;
        uart_send(`LP_OP_RGB_EN);
        uart_send({noise[4:0], en});
        m_rgb_en = en;
        dirty = 1'b1;
    endtask

    task automatic set_plane_enable(input logic [3:0] en);
        logic [31:0] noise;
        noise = $urandom;
        uart_send(`LP_OP_PLANE_EN);
        uart_send({noise[3:0], en});
        m_plane_en = en;
        dirty = 1'b1;
    endtask

    // n full frames after the current one
    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n + 1;
        while (frame_cnt < target) begin
            @(negedge clk_root);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int seed;
        logic [31:0] rnd;
        logic [7:0] op;
        logic [2:0] rgb;
        logic [3:0] pen;
        seed = 33777;
        void'($urandom(seed));
        rx = 1'b1;
        arst_n = 1'b0;
        dirty = 1'b0;
        loaded = 1'b0;
        m_rgb_en = 3'b111;
        m_plane_en = '1;
        repeat (5) @(negedge clk_root);
        arst_n = 1'b1;

        for (int yi = 0; yi < `LP_HEIGHT; yi++) begin
            for (int xi = 0; xi < `LP_WIDTH; xi++) begin
                rnd = $urandom;
                write_pixel(xi[3:0], yi[2:0], rnd[11:0]);
            end
        end
        loaded = 1'b1;
        wait_frames(2);

        rnd = $urandom;
        rgb = (rnd[2:0] == 3'b111) ? 3'b101 : rnd[2:0]; // mask at least one channel
        set_rgb_enable(rgb);
        wait_frames(1);
        set_rgb_enable(3'b111);

        rnd = $urandom;
        pen = (rnd[3:0] == 4'hf) ? 4'ha : rnd[3:0];
        set_plane_enable(pen);
        wait_frames(1);
        set_plane_enable(4'hf);

        for (int i = 0; i < N_OVERWRITE; i++) begin
            rnd = $urandom;
            op = rnd[7:0];
            if (op inside {`LP_OP_PIXEL, `LP_OP_RGB_EN, `LP_OP_PLANE_EN}) begin
                op = op ^ 8'h01; // none of the opcodes is one bit from another
            end
            uart_send(op);
            write_pixel(rnd[11:8], rnd[14:12], rnd[27:16]);
        end
        wait_frames(1);

        $display("errors: pixel %0d, timing %0d, planes compared %0d",
            pix_err, tim_err, pix_checks / `LP_WIDTH);
        if (pix_checks == 0) begin
            $display("no pixel was ever compared against the model");
        end
        if (pix_err == 0 && tim_err == 0 && pix_checks > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
